//--- project.f
+incdir+test
logic/legal_move_pkg.sv
logic/castle_check.sv
logic/en_passant_gen.sv
logic/move_gen_ctrl.sv
logic/move_fifo.sv
logic/legal_move_gen.sv
test/legal_move_gen_tb.sv

//--- test/move_ref.svh
`ifndef MOVE_REF_SVH
`define MOVE_REF_SVH

// expected batches, built square by square from the move rules

function automatic square_code_t square_at(board_t b, int col, int row);
	return b[row * 8 + col];
endfunction

function automatic logic white_piece(board_t b, int col, int row, piece_t pc);
	square_code_t s;
	s = square_at(b, col, row);
	return (s.piece == pc) && (s.color == 1'b0);
endfunction

function automatic logic vacant(board_t b, int col, int row);
	square_code_t s;
	s = square_at(b, col, row);
	return s.piece == PC_EMPTY; // colour bit ignored
endfunction

function automatic move_t make_move(move_flags_t flags, int from_col, int from_row,
		int to_col, int to_row);
	move_t m;
	m.flags = flags;
	m.from = {3'(from_col), 3'(from_row)};
	m.to = {3'(to_col), 3'(to_row)};
	return m;
endfunction

// a batch is written only when some slot holds a real move
function automatic logic batch_has_move(move_batch_t batch);
	for (int i = 0; i < BATCH_MOVES; i++) begin
		if (!batch[i].flags.invalid)
			return 1'b1;
	end
	return 1'b0;
endfunction

function automatic move_batch_t expected_castle(board_t b, logic lcas, logic rcas);
	move_batch_t batch;
	logic king_ok;
	for (int i = 0; i < BATCH_MOVES; i++)
		batch[i] = INVALID_MOVE;
	king_ok = white_piece(b, 4, 0, PC_KING);
	if (rcas && king_ok && vacant(b, 5, 0) && vacant(b, 6, 0) && white_piece(b, 7, 0, PC_ROOK))
		batch[0] = make_move(FLAGS_CASTLE, 4, 0, 6, 0); // e1 to g1
	if (lcas && king_ok && white_piece(b, 0, 0, PC_ROOK) && vacant(b, 1, 0) &&
			vacant(b, 2, 0) && vacant(b, 3, 0))
		batch[1] = make_move(FLAGS_CASTLE, 4, 0, 2, 0); // e1 to c1
	return batch;
endfunction

function automatic move_batch_t expected_en_passant(board_t b, logic [7:0] files);
	move_batch_t batch;
	int f;
	for (int i = 0; i < BATCH_MOVES; i++)
		batch[i] = INVALID_MOVE;
	f = -1;
	for (int i = 0; i < 8; i++) begin
		if (files[i] && (f < 0))
			f = i;
	end
	if (f >= 0) begin
		if ((f > 0) && white_piece(b, f - 1, 4, PC_PAWN))
			batch[0] = make_move(FLAGS_EN_PASSANT, f - 1, 4, f, 5);
		if ((f < 7) && white_piece(b, f + 1, 4, PC_PAWN))
			batch[1] = make_move(FLAGS_EN_PASSANT, f + 1, 4, f, 5);
	end
	return batch;
endfunction

`endif

//--- test/legal_move_gen_tb.sv
`timescale 1ns/10ps
`default_nettype none

module legal_move_gen_tb;
	import legal_move_pkg::*;

	`include "move_ref.svh"

	localparam int N_RANDOM = 18;
	localparam int N_RUNS = 14 + N_RANDOM;
	localparam int WATCHDOG_CYCLES = (N_RUNS + 1) * 20;

	logic clk = 1'b0;
	logic reset;
	logic start;
	board_t board;
	logic lcas_ok;
	logic rcas_ok;
	logic [7:0] enp_files;
	logic rden;
	move_batch_t fifo_out;
	logic fifo_empty;
	logic done;

	move_batch_t exp_q[$]; // batches in the order the FIFO should deliver them
	int error_count = 0;

	legal_move_gen u_dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.board(board),
		.lcas_ok(lcas_ok),
		.rcas_ok(rcas_ok),
		.enp_files(enp_files),
		.rden(rden),
		.fifo_out(fifo_out),
		.fifo_empty(fifo_empty),
		.done(done)
	);

	always #5 clk = ~clk;

	task automatic stop_run(string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(string name, logic [$bits(move_batch_t)-1:0] got,
			logic [$bits(move_batch_t)-1:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("Error: %s is %h, expected %h", name, got, exp);
			stop_run($sformatf("%s does not match the reference", name));
		end
	endtask

	function automatic board_t put_piece(board_t b, int col, int row, logic color, piece_t pc);
		b[row * 8 + col] = '{color: color, piece: pc};
		return b;
	endfunction

	function automatic board_t random_board();
		board_t b;
		for (int i = 0; i < 64; i++)
			b[i] = '{color: 1'($urandom_range(0, 1)), piece: piece_t'($urandom_range(0, 7))};
		return b;
	endfunction

	// rank 1 ready for both castles, empty squares with a random colour bit
	function automatic board_t castle_setup(board_t b);
		b = put_piece(b, 0, 0, 1'b0, PC_ROOK);
		for (int c = 1; c < 4; c++)
			b = put_piece(b, c, 0, 1'($urandom_range(0, 1)), PC_EMPTY);
		b = put_piece(b, 4, 0, 1'b0, PC_KING);
		b = put_piece(b, 5, 0, 1'($urandom_range(0, 1)), PC_EMPTY);
		b = put_piece(b, 6, 0, 1'($urandom_range(0, 1)), PC_EMPTY);
		return put_piece(b, 7, 0, 1'b0, PC_ROOK);
	endfunction

	task automatic run_position(board_t b, logic lcas, logic rcas, logic [7:0] files);
		move_batch_t exp_castle;
		move_batch_t exp_enp;
		int cycles;
		exp_castle = expected_castle(b, lcas, rcas);
		exp_enp = expected_en_passant(b, files);
		if (batch_has_move(exp_castle))
			exp_q.push_back(exp_castle);
		if (batch_has_move(exp_enp))
			exp_q.push_back(exp_enp);
		board = b;
		lcas_ok = lcas;
		rcas_ok = rcas;
		enp_files = files;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		board = random_board(); // the run must use the sampled copy
		lcas_ok = ~lcas;
		rcas_ok = ~rcas;
		enp_files = ~files;
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (!done && (cycles < 8));
		check_value("done latency in cycles", cycles, 3);
		check_value("fifo_empty", fifo_empty, exp_q.size() == 0);
		while (!fifo_empty) begin
			rden = 1'b1;
			@(posedge clk);
			#1;
			rden = 1'b0;
		end
		check_value("batches still expected", exp_q.size(), 0);
	endtask

	// head is compared half a cycle before the pop edge
	always @(negedge clk) begin
		if (!reset && rden && !fifo_empty) begin
			if (exp_q.size() == 0) begin
				stop_run("the DUT delivered a batch that was not expected");
			end else begin
				check_value("fifo_out", fifo_out, exp_q[0]);
				exp_q.delete(0);
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_run("watchdog timeout, the runs did not finish in time");
	end

	initial begin
		board_t b;
		logic [7:0] files;
		void'($urandom(93299));
		reset = 1'b1;
		start = 1'b0;
		board = '0;
		lcas_ok = 1'b0;
		rcas_ok = 1'b0;
		enp_files = 8'h00;
		rden = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		check_value("fifo_empty", fifo_empty, 1);
		check_value("done", done, 0);

		b = castle_setup(random_board());
		run_position(b, 1'b1, 1'b1, 8'h00); // both sides
		run_position(b, 1'b1, 1'b0, 8'h00);
		run_position(b, 1'b0, 1'b1, 8'h00);
		run_position(put_piece(b, 5, 0, 1'b0, PC_KNIGHT), 1'b1, 1'b1, 8'h00); // f1 blocked
		run_position(put_piece(b, 1, 0, 1'b1, PC_BISHOP), 1'b1, 1'b1, 8'h00); // b1 blocked
		run_position(put_piece(b, 7, 0, 1'b0, PC_EMPTY), 1'b1, 1'b1, 8'h00);
		run_position(put_piece(b, 0, 0, 1'b1, PC_ROOK), 1'b1, 1'b1, 8'h00); // black a1 rook

		b = put_piece(put_piece(random_board(), 2, 4, 1'b0, PC_PAWN), 4, 4, 1'b0, PC_PAWN);
		run_position(b, 1'b0, 1'b0, 8'h08); // d file, c5 and e5
		run_position(put_piece(put_piece(random_board(), 1, 4, 1'b0, PC_PAWN),
			7, 4, 1'b0, PC_PAWN), 1'b0, 1'b0, 8'h01); // h5 is no neighbour of the a file
		run_position(put_piece(put_piece(random_board(), 6, 4, 1'b0, PC_PAWN),
			0, 4, 1'b0, PC_PAWN), 1'b0, 1'b0, 8'h80); // a5 is no neighbour of the h file
		b = put_piece(put_piece(b, 1, 4, 1'b0, PC_PAWN), 3, 4, 1'b0, PC_PAWN);
		b = put_piece(b, 6, 4, 1'b0, PC_PAWN);
		run_position(b, 1'b0, 1'b0, 8'h24); // c and f flagged, c counts

		run_position('0, 1'b1, 1'b1, 8'h10); // bare board, nothing to write
		run_position(random_board(), 1'b0, 1'b0, 8'h00);
		b = put_piece(put_piece(castle_setup(random_board()), 3, 4, 1'b0, PC_PAWN),
			5, 4, 1'b0, PC_PAWN);
		run_position(b, 1'b1, 1'b1, 8'h10); // castling then en passant

		for (int i = 0; i < N_RANDOM; i++) begin
			b = random_board();
			if ($urandom_range(0, 1))
				b = castle_setup(b);
			case ($urandom_range(0, 2))
				0: files = 8'h00;
				1: files = 8'h01 << $urandom_range(0, 7);
				default: files = 8'($urandom);
			endcase
			for (int c = 0; c < 8; c++) begin
				if ($urandom_range(0, 1))
					b = put_piece(b, c, 4, 1'b0, PC_PAWN);
			end
			run_position(b, 1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)), files);
		end

		if (error_count == 0) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			stop_run("checks reported mismatches");
		end
	end

endmodule

`default_nettype wire

//--- logic/legal_move_gen.sv
`timescale 1ns/10ps
`default_nettype none

module legal_move_gen (
	input wire clk,
	input wire reset,
	input wire start,
	input wire legal_move_pkg::board_t board,
	input wire lcas_ok,
	input wire rcas_ok,
	input wire [7:0] enp_files,
	input wire rden,
	output legal_move_pkg::move_batch_t fifo_out,
	output logic fifo_empty,
	output logic done
);
	import legal_move_pkg::*;

	board_t board_q;
	logic lcas_q;
	logic rcas_q;
	logic [7:0] enp_q;
	move_batch_t castle_batch;
	move_batch_t enp_batch;
	logic castle_found;
	logic enp_found;
	logic wr_en;
	move_batch_t wr_batch;

	move_gen_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.start(start),
		.board(board),
		.lcas_ok(lcas_ok),
		.rcas_ok(rcas_ok),
		.enp_files(enp_files),
		.castle_batch(castle_batch),
		.enp_batch(enp_batch),
		.castle_found(castle_found),
		.enp_found(enp_found),
		.board_q(board_q),
		.lcas_q(lcas_q),
		.rcas_q(rcas_q),
		.enp_q(enp_q),
		.wr_en(wr_en),
		.wr_batch(wr_batch),
		.done(done)
	);

	castle_check u_castle (
		.board(board_q),
		.lcas_ok(lcas_q),
		.rcas_ok(rcas_q),
		.batch(castle_batch),
		.found(castle_found)
	);

	en_passant_gen u_enp (
		.board(board_q),
		.enp_files(enp_q),
		.batch(enp_batch),
		.found(enp_found)
	);

	move_fifo u_fifo (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_batch(wr_batch),
		.rden(rden),
		.fifo_out(fifo_out),
		.fifo_empty(fifo_empty),
		.full()
	);

endmodule

`default_nettype wire

//--- logic/move_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module move_fifo (
	input wire clk,
	input wire reset,
	input wire wr_en,
	input wire legal_move_pkg::move_batch_t wr_batch,
	input wire rden,
	output legal_move_pkg::move_batch_t fifo_out,
	output logic fifo_empty,
	output logic full
);
	import legal_move_pkg::*;

	move_batch_t mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(FIFO_DEPTH+1)-1:0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en && !full; // dropped when full
	assign do_rd = rden && !fifo_empty;

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_batch;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	// show-ahead head entry
	assign fifo_out = mem[rd_ptr];

	assign fifo_empty = (count == 0);
	assign full = (count == FIFO_DEPTH);

	// the host is expected to drain between runs
	a_no_write_full: assert property (@(posedge clk) disable iff (reset)
		!(wr_en && full));

	a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
		!(rden && fifo_empty));

endmodule

`default_nettype wire

//--- logic/move_gen_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module move_gen_ctrl (
	input wire clk,
	input wire reset,
	input wire start,
	input wire legal_move_pkg::board_t board,
	input wire lcas_ok,
	input wire rcas_ok,
	input wire [7:0] enp_files,
	input wire legal_move_pkg::move_batch_t castle_batch,
	input wire legal_move_pkg::move_batch_t enp_batch,
	input wire castle_found,
	input wire enp_found,
	output legal_move_pkg::board_t board_q,
	output logic lcas_q,
	output logic rcas_q,
	output logic [7:0] enp_q,
	output logic wr_en,
	output legal_move_pkg::move_batch_t wr_batch,
	output logic done
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CASTLE,
		ST_ENP,
		ST_DONE
	} state_t;

	state_t state;
	state_t state_nxt;
	logic start_ok;

	assign start_ok = start && ((state == ST_IDLE) || (state == ST_DONE));

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE, ST_DONE: begin
				if (start)
					state_nxt = ST_CASTLE;
			end
			ST_CASTLE: state_nxt = ST_ENP;
			ST_ENP: state_nxt = ST_DONE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			done <= 1'b0;
		end else begin
			state <= state_nxt;
			if (start_ok)
				done <= 1'b0;
			else if (state == ST_DONE)
				done <= 1'b1; // one cycle after the last write slot
		end
	end

	// inputs held steady for the generators during the run
	always_ff @(posedge clk) begin
		if (start_ok) begin
			board_q <= board;
			lcas_q <= lcas_ok;
			rcas_q <= rcas_ok;
			enp_q <= enp_files;
		end
	end

	// castling goes out first, en passant right after
	assign wr_en = (state == ST_CASTLE) ? castle_found : ((state == ST_ENP) && enp_found);
	assign wr_batch = (state == ST_ENP) ? enp_batch : castle_batch;

	// a write only ever follows an accepted start by one or two cycles
	a_wr_after_start: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> ($past(start_ok) || $past(start_ok, 2)));

	// done stays low three cycles after start, then rises
	a_done_timing: assert property (@(posedge clk) disable iff (reset)
		start_ok |=> !done [*3] ##1 done);

endmodule

`default_nettype wire

//--- logic/en_passant_gen.sv
`timescale 1ns/10ps
`default_nettype none

module en_passant_gen (
	input wire legal_move_pkg::board_t board,
	input wire [7:0] enp_files,
	output legal_move_pkg::move_batch_t batch,
	output logic found
);
	import legal_move_pkg::*;

	logic [2:0] file;
	logic has_flag;
	logic [2:0] left_col;
	logic [2:0] right_col;
	logic left_ok;
	logic right_ok;
	square_t target_sq;

	// only one double push can have just happened, lowest flag wins
	always_comb begin
		file = 3'd0;
		for (int f = 7; f >= 0; f--) begin
			if (enp_files[f])
				file = 3'(f);
		end
	end

	assign has_flag = |enp_files;

	assign left_col = file - 3'd1;
	assign right_col = file + 3'd1;

	assign target_sq = {file, TARGET_ROW};

	// board entry index is {row, column}
	assign left_ok = has_flag &&
		(file != 3'd0) &&
		is_white(board[{CAPTURE_ROW, left_col}], PC_PAWN);

	assign right_ok = has_flag &&
		(file != 3'd7) && // h file has no right neighbour
		is_white(board[{CAPTURE_ROW, right_col}], PC_PAWN);

	always_comb begin
		for (int i = 0; i < BATCH_MOVES; i++) begin
			batch[i] = INVALID_MOVE;
		end
		if (left_ok) begin
			batch[0] = '{
				flags: FLAGS_EN_PASSANT,
				from: {left_col, CAPTURE_ROW},
				to: target_sq
			};
		end
		if (right_ok) begin
			batch[1] = '{
				flags: FLAGS_EN_PASSANT,
				from: {right_col, CAPTURE_ROW},
				to: target_sq
			};
		end
	end

	assign found = left_ok | right_ok;

endmodule

`default_nettype wire

//--- logic/castle_check.sv
`timescale 1ns/10ps
`default_nettype none

module castle_check (
	input wire legal_move_pkg::board_t board,
	input wire lcas_ok,
	input wire rcas_ok,
	output legal_move_pkg::move_batch_t batch,
	output logic found
);
	import legal_move_pkg::*;

	logic king_home;
	logic cas_k;
	logic cas_q;

	// rank 1 squares sit at entries 0..7, a1 first
	assign king_home = is_white(board[4], PC_KING); // e1

	// no check or attacked-square test, only pieces and rights
	assign cas_k = king_home &&
		is_empty(board[5]) && // f1
		is_empty(board[6]) && // g1
		is_white(board[7], PC_ROOK) &&
		rcas_ok;

	assign cas_q = king_home &&
		is_white(board[0], PC_ROOK) &&
		is_empty(board[1]) &&
		is_empty(board[2]) &&
		is_empty(board[3]) &&
		lcas_ok;

	always_comb begin
		for (int i = 0; i < BATCH_MOVES; i++) begin
			batch[i] = INVALID_MOVE;
		end
		if (cas_k)
			batch[0] = '{flags: FLAGS_CASTLE, from: SQ_E1, to: SQ_G1}; // kingside
		if (cas_q)
			batch[1] = '{flags: FLAGS_CASTLE, from: SQ_E1, to: SQ_C1}; // queenside
	end

	assign found = cas_k | cas_q;

endmodule

`default_nettype wire

//--- logic/legal_move_pkg.sv
`default_nettype none

package legal_move_pkg;

	localparam int BATCH_MOVES = 8; // moves per batch
	localparam int FIFO_DEPTH = 4; // batches held by the output fifo

	localparam logic WHITE = 1'b0;
	localparam logic BLACK = 1'b1;

	typedef enum logic [2:0] {
		PC_EMPTY,
		PC_PAWN,
		PC_KNIGHT,
		PC_BISHOP,
		PC_ROOK,
		PC_QUEEN,
		PC_KING,
		PC_UNUSED
	} piece_t;

	typedef struct packed {
		logic color; // 0 for white
		piece_t piece;
	} square_code_t;

	// entry r*8+c, row 0 is rank 1, column 0 is file a
	typedef square_code_t [63:0] board_t;

	typedef logic [5:0] square_t; // {column, row}

	typedef struct packed {
		logic invalid;
		logic promote;
		logic pawn_move;
		logic pawn_double;
		logic en_passant;
		logic castle;
		logic capture;
	} move_flags_t;

	typedef struct packed {
		move_flags_t flags;
		square_t from;
		square_t to;
	} move_t;

	typedef move_t [BATCH_MOVES-1:0] move_batch_t; // slot 0 at the low end

	localparam move_flags_t FLAGS_CASTLE = '{castle: 1'b1, default: 1'b0};
	localparam move_flags_t FLAGS_EN_PASSANT =
		'{pawn_move: 1'b1, en_passant: 1'b1, capture: 1'b1, default: 1'b0};

	localparam move_t INVALID_MOVE = '{
		flags: '{invalid: 1'b1, default: 1'b0},
		from: 6'o00,
		to: 6'o00
	};

	localparam square_t SQ_E1 = 6'o40;
	localparam square_t SQ_G1 = 6'o60;
	localparam square_t SQ_C1 = 6'o20;

	localparam logic [2:0] CAPTURE_ROW = 3'd4; // rank 5
	localparam logic [2:0] TARGET_ROW = 3'd5; // rank 6

	// colour only counts when the square holds a piece
	function automatic logic is_white(square_code_t sq, piece_t pc);
		return (sq.color == WHITE) && (sq.piece == pc);
	endfunction

	function automatic logic is_empty(square_code_t sq);
		return sq.piece == PC_EMPTY;
	endfunction

endpackage

`default_nettype wire
